// File: src.f
rtl/rename_pkg.sv
rtl/phys_reg_file.sv
rtl/rob_tag_counter.sv
rtl/dispatch_ctrl.sv
rtl/rename_core.sv
tests/rename_core_properties.sv
tests/rename_core_tb.sv

// File: Bender.yml
package:
  name: rename_core

sources:
  - rtl/rename_pkg.sv
  - rtl/phys_reg_file.sv
  - rtl/rob_tag_counter.sv
  - rtl/dispatch_ctrl.sv
  - rtl/rename_core.sv
  - target: test
    files:
      - tests/rename_core_properties.sv
      - tests/rename_core_tb.sv

// File: tests/rename_core_tb.sv
// Rename core testbench
`timescale 1ns/1ps

module rename_core_tb;

    localparam int NUM_INSTS = 400;
    localparam int ROB_DEPTH = 8;

    logic                       clk;
    logic                       rst;
    logic                       req;
    rename_pkg::dispatch_req_t  inst;
    logic                       ack;
    rename_pkg::dispatch_resp_t resp;
    rename_pkg::cdb_t           cdb;

    // Reference model of the register file and ROB
    logic [rename_pkg::XLEN-1:0] model_value   [rename_pkg::NUM_PREGS];
    logic                        model_pending [rename_pkg::NUM_PREGS];
    rename_pkg::rob_id_t         model_tag     [rename_pkg::NUM_PREGS];
    rename_pkg::rob_id_t         model_next_tag;
    int                          model_count;
    logic                        model_ack;
    rename_pkg::dispatch_resp_t  exp_resp;

    // Outstanding writers with the oldest first
    rename_pkg::rob_id_t   out_tag [$];
    rename_pkg::preg_idx_t out_rd  [$];

    logic [31:0] lcg_state = 32'h508c;
    logic        ack_seen;
    int          sent_count;
    int          done_count;
    int          gap;
    int          stall_cycles;
    int          full_hits;

    rename_core #(
        .ROB_DEPTH (ROB_DEPTH)
    ) rename_core_inst (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .inst (inst),
        .ack  (ack),
        .resp (resp),
        .cdb  (cdb)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 8) % 32'(n));
    endfunction

    // Operand as the capture cycle should see it with the bypass
    function automatic rename_pkg::operand_resp_t expect_operand(
        input rename_pkg::preg_idx_t idx
    );
        rename_pkg::operand_resp_t r;
        r = '0;
        if (idx == '0) begin
            r.ready = 1'b1;
        end else if (cdb.valid && cdb.rd == idx && cdb.tag == model_tag[idx]) begin
            r.ready         = 1'b1;
            r.operand.value = cdb.value;
        end else if (model_pending[idx]) begin
            r.ready              = 1'b0;
            r.operand.tag.rob_id = model_tag[idx];
        end else begin
            r.ready         = 1'b1;
            r.operand.value = model_value[idx];
        end
        return r;
    endfunction

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t: %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("ack is %b, expected %b", got, exp));
        end
    endtask

    task automatic check_operand(
        input string                     name,
        input rename_pkg::operand_resp_t got,
        input rename_pkg::operand_resp_t exp
    );
        if (got.ready !== exp.ready) begin
            report_mismatch($sformatf("%s ready is %b, expected %b",
                                      name, got.ready, exp.ready));
        end else if (exp.ready && got.operand.value !== exp.operand.value) begin
            report_mismatch($sformatf("%s value is %h, expected %h",
                                      name, got.operand.value, exp.operand.value));
        end else if (!exp.ready && got.operand.tag.rob_id !== exp.operand.tag.rob_id) begin
            report_mismatch($sformatf("%s tag is %0d, expected %0d", name,
                                      got.operand.tag.rob_id, exp.operand.tag.rob_id));
        end
    endtask

    task automatic check_resp(
        input rename_pkg::dispatch_resp_t got,
        input rename_pkg::dispatch_resp_t exp
    );
        if (got.tag !== exp.tag) begin
            report_mismatch($sformatf("resp tag is %0d, expected %0d", got.tag, exp.tag));
        end
        check_operand("rs1", got.rs1, exp.rs1);
        check_operand("rs2", got.rs2, exp.rs2);
    endtask

    // Dispatcher and CDB inputs for the cycle that starts now
    task automatic drive_cycle();
        rename_pkg::dispatch_req_t next_inst;
        rename_pkg::cdb_t          next_cdb;
        logic                      quiet;
        logic                      retire;
        int                        k;
        if (req && ack_seen) begin
            req <= 1'b0;
            done_count++;
        end else if (!req && !ack_seen && sent_count < NUM_INSTS) begin
            if (gap == 0) begin
                next_inst.rd  = rename_pkg::preg_idx_t'(rand_below(12));
                next_inst.rs1 = rename_pkg::preg_idx_t'(rand_below(12));
                next_inst.rs2 = rename_pkg::preg_idx_t'(rand_below(16));
                req  <= 1'b1;
                inst <= next_inst;
                sent_count++;
                gap = rand_below(4);
            end else begin
                gap--;
            end
        end
        // Every other block of 50 runs without writebacks until the ROB stalls
        quiet    = ((sent_count / 50) % 2) == 1;
        next_cdb = '0;
        retire   = 1'b0;
        if (out_tag.size() > 0) begin
            retire = quiet ? (stall_cycles >= 4) : (rand_below(2) == 0);
        end
        if (retire) begin
            k              = rand_below(out_tag.size());
            next_cdb.valid = 1'b1;
            next_cdb.rd    = out_rd[k];
            next_cdb.tag   = out_tag[k];
            next_cdb.value = lcg_next();
            out_tag.delete(k);
            out_rd.delete(k);
        end
        cdb <= next_cdb;
    endtask

    // Check this cycle's outputs and advance the model past the next edge
    task automatic step_model();
        logic capture;
        if (rename_core_inst.props_inst.fail_count != 0) begin
            $display("ERROR: a handshake or occupancy assertion failed");
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
        check_ack(ack, model_ack);
        if (model_ack) begin
            check_resp(resp, exp_resp);
        end
        capture = !model_ack && req && (model_count < ROB_DEPTH);
        if (capture) begin
            exp_resp.tag = model_next_tag;
            exp_resp.rs1 = expect_operand(inst.rs1);
            exp_resp.rs2 = expect_operand(inst.rs2);
        end
        // A stale tag leaves the entry pending
        if (cdb.valid && cdb.rd != '0 && cdb.tag == model_tag[cdb.rd]) begin
            if (!(capture && inst.rd == cdb.rd)) begin
                model_value[cdb.rd]   = cdb.value;
                model_pending[cdb.rd] = 1'b0;
            end
        end
        if (capture) begin
            if (inst.rd != '0) begin
                model_pending[inst.rd] = 1'b1;
                model_tag[inst.rd]     = model_next_tag;
            end
            out_tag.push_back(model_next_tag);
            out_rd.push_back(inst.rd);
            model_next_tag = rename_pkg::rob_id_t'((model_next_tag + 1) % ROB_DEPTH);
            model_ack      = 1'b1;
        end else if (model_ack && !req) begin
            model_ack = 1'b0;
        end
        model_count = model_count + int'(capture) - int'(cdb.valid);
        if (req && !model_ack && model_count == ROB_DEPTH) begin
            if (stall_cycles == 0) begin
                full_hits++;
            end
            stall_cycles++;
        end else begin
            stall_cycles = 0;
        end
        ack_seen = ack;
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        req            = 1'b0;
        inst           = '0;
        cdb            = '0;
        model_next_tag = '0;
        model_count    = 0;
        model_ack      = 1'b0;
        exp_resp       = '0;
        ack_seen       = 1'b0;
        sent_count     = 0;
        done_count     = 0;
        gap            = 0;
        stall_cycles   = 0;
        full_hits      = 0;
        for (int i = 0; i < rename_pkg::NUM_PREGS; i++) begin
            model_value[i]   = '0;
            model_pending[i] = 1'b0;
            model_tag[i]     = '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        while (done_count < NUM_INSTS || ack_seen) begin
            @(posedge clk);
            drive_cycle();
            @(negedge clk);
            step_model();
        end
        if (full_hits == 0) begin
            $display("ERROR: the ROB never filled up, back-pressure was not exercised");
            $display("*** TEST FAILED ***");
            $fatal(1);
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    // Hang guard
    initial begin
        repeat (16 + NUM_INSTS * 64) @(posedge clk);
        $display("ERROR: watchdog expired, the core stopped answering dispatch requests");
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

endmodule

// File: tests/rename_core_properties.sv
// Handshake and occupancy assertions
`timescale 1ns/1ps

module rename_core_properties (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input logic alloc,
    input logic cdb_valid
);

    // Entries allocated and not yet written back
    logic [4:0] occupancy;

    // Assertion failures so far
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + 5'(alloc) - 5'(cdb_valid);
        end
    end

    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(ack) |-> $past(req)
    ) else begin
        $error("ack rose without a pending request");
        fail_count++;
    end

    ack_waits_release: assert property (
        @(posedge clk) disable iff (rst) $fell(ack) |-> $past(!req)
    ) else begin
        $error("ack fell while req was still high");
        fail_count++;
    end

    no_cdb_when_empty: assert property (
        @(posedge clk) disable iff (rst) cdb_valid |-> (occupancy != '0)
    ) else begin
        $error("CDB writeback with no outstanding ROB entry");
        fail_count++;
    end

endmodule

bind rename_core rename_core_properties props_inst (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .ack       (ack),
    .alloc     (alloc),
    .cdb_valid (cdb.valid)
);

// File: rtl/rename_core.sv
// Operand read and wakeup core
`timescale 1ns/1ps

module rename_core #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  rename_pkg::dispatch_req_t  inst,
    output logic                       ack,
    output rename_pkg::dispatch_resp_t resp,
    input  rename_pkg::cdb_t           cdb
);

    logic                      alloc;
    logic                      full;
    rename_pkg::rob_id_t       next_tag;
    rename_pkg::operand_resp_t rs1_data;
    rename_pkg::operand_resp_t rs2_data;

    dispatch_ctrl ctrl_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .inst     (inst),
        .full     (full),
        .next_tag (next_tag),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .alloc    (alloc),
        .ack      (ack),
        .resp     (resp)
    );

    // Every writeback retires one ROB slot
    rob_tag_counter #(
        .ROB_DEPTH (ROB_DEPTH)
    ) tag_counter_inst (
        .clk      (clk),
        .rst      (rst),
        .alloc    (alloc),
        .free     (cdb.valid),
        .next_tag (next_tag),
        .full     (full)
    );

    // rd is marked with the tag being allocated this cycle
    phys_reg_file reg_file_inst (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (alloc),
        .wr_rd    (inst.rd),
        .wr_tag   (next_tag),
        .cdb      (cdb),
        .rs1_idx  (inst.rs1),
        .rs2_idx  (inst.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

// File: rtl/dispatch_ctrl.sv
// Dispatch handshake controller
// Four-phase req/ack with registered response
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  rename_pkg::dispatch_req_t  inst,
    input  logic                       full,
    input  rename_pkg::rob_id_t        next_tag,
    input  rename_pkg::operand_resp_t  rs1_data,
    input  rename_pkg::operand_resp_t  rs2_data,
    output logic                       alloc,
    output logic                       ack,
    output rename_pkg::dispatch_resp_t resp
);

    typedef enum logic {
        IDLE,
        ACK
    } state_t;

    state_t state;
    state_t state_next;

    // Capture when a request is waiting and the ROB has room
    logic capture;

    assign capture = (state == IDLE) && req && !full;

    // Register file and counter act on the same edge
    assign alloc = capture;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (capture) begin
                    state_next = ACK;
                end
            end
            ACK: begin
                // Hold until the dispatcher lets go
                if (!req) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign ack = (state == ACK);

    // Response frozen for the whole ACK phase
    always_ff @(posedge clk) begin
        if (capture) begin
            resp.tag <= next_tag;
            resp.rs1 <= rs1_data;
            resp.rs2 <= rs2_data;
        end
    end

endmodule

// File: rtl/rob_tag_counter.sv
// In-order ROB tag allocator
`timescale 1ns/1ps

module rob_tag_counter #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc,
    input  logic                free,
    output rename_pkg::rob_id_t next_tag,
    output logic                full
);

    localparam int CNT_BITS = $clog2(ROB_DEPTH + 1);

    // Entries currently outstanding
    logic [CNT_BITS-1:0] count;

    // Tag handed out on the next alloc
    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag <= '0;
        end else if (alloc) begin
            if (next_tag == rename_pkg::rob_id_t'(ROB_DEPTH - 1)) begin
                next_tag <= '0;
            end else begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    // Alloc and free may coincide
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({alloc, free})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full = (count == CNT_BITS'(ROB_DEPTH));

endmodule

// File: rtl/phys_reg_file.sv
// Physical register file
// Pending tracking and CDB bypass
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  rename_pkg::preg_idx_t     wr_rd,
    input  rename_pkg::rob_id_t       wr_tag,
    input  rename_pkg::cdb_t          cdb,
    input  rename_pkg::preg_idx_t     rs1_idx,
    input  rename_pkg::preg_idx_t     rs2_idx,
    output rename_pkg::operand_resp_t rs1_data,
    output rename_pkg::operand_resp_t rs2_data
);

    logic [rename_pkg::XLEN-1:0]      value_q [rename_pkg::NUM_PREGS];
    rename_pkg::rob_id_t              tag_q   [rename_pkg::NUM_PREGS];
    logic [rename_pkg::NUM_PREGS-1:0] pending_q;

    // Entry hit by this cycle's writeback
    logic [rename_pkg::NUM_PREGS-1:0] cdb_hit;

    always_comb begin
        for (int i = 0; i < rename_pkg::NUM_PREGS; i++) begin
            cdb_hit[i] = cdb.valid
                      && (cdb.rd == rename_pkg::preg_idx_t'(i))
                      && (cdb.tag == tag_q[i]);
        end
    end

    // Entry 0 keeps its reset state for good
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::NUM_PREGS; i++) begin
                value_q[i]   <= '0;
                tag_q[i]     <= '0;
                pending_q[i] <= 1'b0;
            end
        end else begin
            for (int i = 1; i < rename_pkg::NUM_PREGS; i++) begin
                if (wr_en && (wr_rd == rename_pkg::preg_idx_t'(i))) begin
                    // Newer producer wins over a same-cycle writeback
                    pending_q[i] <= 1'b1;
                    tag_q[i]     <= wr_tag;
                end else if (cdb_hit[i]) begin
                    value_q[i]   <= cdb.value;
                    pending_q[i] <= 1'b0;
                end
            end
        end
    end

    function automatic rename_pkg::operand_resp_t read_operand(
        input rename_pkg::preg_idx_t idx
    );
        rename_pkg::operand_resp_t r;
        r = '0;
        if (idx == '0) begin
            // x0 reads as ready zero
            r.ready = 1'b1;
        end else if (cdb_hit[idx]) begin
            r.ready         = 1'b1;
            r.operand.value = cdb.value;
        end else if (pending_q[idx]) begin
            r.ready              = 1'b0;
            r.operand.tag.rob_id = tag_q[idx];
        end else begin
            r.ready         = 1'b1;
            r.operand.value = value_q[idx];
        end
        return r;
    endfunction

    // Both dispatch sources
    always_comb begin
        rs1_data = read_operand(rs1_idx);
        rs2_data = read_operand(rs2_idx);
    end

endmodule

// File: rtl/rename_pkg.sv
// Rename and operand-read shared types

package rename_pkg;

    // Physical register file geometry
    localparam int NUM_PREGS   = 32;
    localparam int PREG_BITS   = 5;
    localparam int XLEN        = 32;

    // Wide enough for any ROB depth up to 16
    localparam int ROB_ID_BITS = 4;

    typedef logic [PREG_BITS-1:0]   preg_idx_t;
    typedef logic [ROB_ID_BITS-1:0] rob_id_t;

    // Tag view of an operand word, tag in the low bits
    typedef struct packed {
        logic [XLEN-ROB_ID_BITS-1:0] pad;
        rob_id_t                     rob_id;
    } operand_tag_t;

    // One word, value when ready, producer tag when pending
    typedef union packed {
        logic [XLEN-1:0] value;
        operand_tag_t    tag;
    } operand_t;

    // ready selects how operand is decoded
    typedef struct packed {
        logic     ready;
        operand_t operand;
    } operand_resp_t;

    // Instruction as seen by the dispatcher
    typedef struct packed {
        preg_idx_t rd;
        preg_idx_t rs1;
        preg_idx_t rs2;
    } dispatch_req_t;

    // Returned with ack
    typedef struct packed {
        rob_id_t       tag;
        operand_resp_t rs1;
        operand_resp_t rs2;
    } dispatch_resp_t;

    // Single writeback port
    typedef struct packed {
        logic            valid;
        preg_idx_t       rd;
        rob_id_t         tag;
        logic [XLEN-1:0] value;
    } cdb_t;

endpackage
